// ==== Bender.yml ====
package:
  name: cpu

sources:
  - source/cpu_pkg.sv
  - source/register_file.sv
  - source/fetch_decode.sv
  - source/sequencer.sv
  - source/execute_unit.sv
  - source/load_store_unit.sv
  - source/cpu_top.sv
  - target: test
    files:
      - verification/cpu_tb_memory.sv
      - verification/cpu_tb.sv

// ==== source/cpu_pkg.sv ====
/*
 * CPU package
 * Widths, opcode/ALU/state enums and the structs that carry the
 * decoded instruction, per-cycle datapath controls and ALU flags
 */
package cpu_pkg;

	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;

	// Major opcodes kept in this core
	typedef enum logic [6:0] {
		ALU_R   = 7'b0110011,
		ALU_IMM = 7'b0010011,
		LOAD    = 7'b0000011,
		STORE   = 7'b0100011,
		LUI     = 7'b0110111,
		BRANCH  = 7'b1100011
	} opcode_e;

	typedef enum logic [2:0] {
		ADD, SUB, XOR, OR, AND, SLL, SRL, SRA
	} alu_op_e;

	typedef enum logic [2:0] {
		RESET, FETCH, DECODE, EXECUTE, RESULT, RETIRE
	} state_e;

	typedef struct packed {
		opcode_e               opcode;
		logic [2:0]            funct3;
		logic                  funct7;  // Instruction bit 30
		logic [REG_ADDR_W-1:0] rs1;
		logic [REG_ADDR_W-1:0] rs2;
		logic [REG_ADDR_W-1:0] rd;
		logic [XLEN-1:0]       imm;
	} decoded_t;

	typedef struct packed {
		logic       load_ab;
		alu_op_e    alu_op;
		logic       op2_imm;
		logic       load_r;
		logic [1:0] y_sel;        // {set-less-than, bit value}, else R
		logic       load_y;
		logic       rf_we;
		logic       rf_from_mem;
		logic       rf_from_imm;
		logic       pc_load;
		logic       pc_branch;    // PC+imm instead of PC+4
		logic       mem_rd;
		logic       mem_wr;
	} ctrl_t;

	typedef struct packed {
		logic z;
		logic n;
		logic c;
		logic v;
	} flags_t;

endpackage

// ==== source/cpu_top.sv ====
/*
 * Multicycle RV32I subset CPU, top level
 * Connects fetch/decode, sequencer, execute unit and load/store unit
 */
`timescale 1ns/1ps

module cpu_top #(
	parameter int NUM_REGS = 32
)(
	input  logic                     clk,
	input  logic                     reset,
	output logic [cpu_pkg::XLEN-1:0] o_pc_addr,
	output logic                     o_pc_rd,
	input  logic [cpu_pkg::XLEN-1:0] i_pc_rddata,
	output logic [3:0]               o_pc_byte_en,
	output logic [cpu_pkg::XLEN-1:0] o_ldst_addr,
	output logic                     o_ldst_rd,
	output logic                     o_ldst_wr,
	input  logic [cpu_pkg::XLEN-1:0] i_ldst_rddata,
	output logic [cpu_pkg::XLEN-1:0] o_ldst_wrdata,
	output logic [3:0]               o_ldst_byte_en,
	input  logic                     i_ldst_waitrequest,
	output logic [cpu_pkg::XLEN-1:0] o_tb_regs [0:NUM_REGS-1]
);
	import cpu_pkg::*;

	decoded_t        decoded;
	ctrl_t           ctrl;
	flags_t          flags;
	logic            capture;
	logic            stall;
	logic [XLEN-1:0] result;
	logic [XLEN-1:0] store_src;
	logic [XLEN-1:0] load_value;

	assign o_pc_byte_en = 4'b1111;  // Instruction reads are whole words

	fetch_decode u_fetch_decode (
		.clk       (clk),
		.reset     (reset),
		.i_instr   (i_pc_rddata),
		.i_capture (capture),
		.o_decoded (decoded)
	);

	sequencer u_sequencer (
		.clk       (clk),
		.reset     (reset),
		.i_decoded (decoded),
		.i_flags   (flags),
		.i_stall   (stall),
		.o_ctrl    (ctrl),
		.o_capture (capture),
		.o_fetch   (o_pc_rd)
	);

	execute_unit #(
		.NUM_REGS (NUM_REGS)
	) u_execute_unit (
		.clk          (clk),
		.reset        (reset),
		.i_ctrl       (ctrl),
		.i_decoded    (decoded),
		.i_load_value (load_value),
		.o_flags      (flags),
		.o_pc         (o_pc_addr),
		.o_result     (result),
		.o_store_src  (store_src),
		.o_regs       (o_tb_regs)
	);

	load_store_unit u_load_store_unit (
		.i_ctrl         (ctrl),
		.i_decoded      (decoded),
		.i_addr         (result),
		.i_store_src    (store_src),
		.i_ldst_rddata  (i_ldst_rddata),
		.i_waitrequest  (i_ldst_waitrequest),
		.o_ldst_rd      (o_ldst_rd),
		.o_ldst_wr      (o_ldst_wr),
		.o_ldst_byte_en (o_ldst_byte_en),
		.o_ldst_addr    (o_ldst_addr),
		.o_ldst_wrdata  (o_ldst_wrdata),
		.o_load_value   (load_value),
		.o_stall        (stall)
	);

endmodule

// ==== source/execute_unit.sv ====
/*
 * Execute unit
 * Operand registers A and B, the ALU with Z/N/C/V flags, the R, M
 * and Y registers, the register file and the PC with +4 and +imm paths
 */
`timescale 1ns/1ps

module execute_unit #(
	parameter int NUM_REGS = 32
)(
	input  logic                     clk,
	input  logic                     reset,
	input  cpu_pkg::ctrl_t           i_ctrl,
	input  cpu_pkg::decoded_t        i_decoded,
	input  logic [cpu_pkg::XLEN-1:0] i_load_value,
	output cpu_pkg::flags_t          o_flags,
	output logic [cpu_pkg::XLEN-1:0] o_pc,
	output logic [cpu_pkg::XLEN-1:0] o_result,
	output logic [cpu_pkg::XLEN-1:0] o_store_src,
	output logic [cpu_pkg::XLEN-1:0] o_regs [0:NUM_REGS-1]
);
	import cpu_pkg::*;

	logic [XLEN-1:0] rf_a;
	logic [XLEN-1:0] rf_b;
	logic [XLEN-1:0] rf_wdata;
	logic [XLEN-1:0] a_q;
	logic [XLEN-1:0] b_q;
	logic [XLEN-1:0] m_q;
	logic [XLEN-1:0] y_q;
	logic [XLEN-1:0] op2;
	logic [XLEN-1:0] alu_res;
	logic            alu_c;
	logic            alu_v;

	assign rf_wdata = i_ctrl.rf_from_mem ? i_load_value :
		i_ctrl.rf_from_imm ? i_decoded.imm : y_q;

	register_file #(
		.NUM_REGS (NUM_REGS)
	) u_register_file (
		.clk      (clk),
		.reset    (reset),
		.i_addr_a (i_decoded.rs1),
		.i_addr_b (i_decoded.rs2),
		.i_addr_w (i_decoded.rd),
		.i_data_w (rf_wdata),
		.i_we     (i_ctrl.rf_we),
		.o_data_a (rf_a),
		.o_data_b (rf_b),
		.o_regs   (o_regs)
	);

	always_ff @(posedge clk) begin
		if (i_ctrl.load_ab) begin
			a_q <= rf_a;
			b_q <= rf_b;
		end
	end

	assign op2 = i_ctrl.op2_imm ? i_decoded.imm : b_q;

	always_comb begin
		alu_c = 1'b0;
		alu_v = 1'b0;
		case (i_ctrl.alu_op)
			ADD: begin
				{alu_c, alu_res} = {1'b0, a_q} + {1'b0, op2};
				alu_v = (a_q[XLEN-1] == op2[XLEN-1]) && (alu_res[XLEN-1] != a_q[XLEN-1]);
			end
			SUB: begin
				{alu_c, alu_res} = {1'b0, a_q} - {1'b0, op2};  // Carry is the borrow
				alu_v = (a_q[XLEN-1] != op2[XLEN-1]) && (alu_res[XLEN-1] != a_q[XLEN-1]);
			end
			XOR: alu_res = a_q ^ op2;
			OR: alu_res = a_q | op2;
			AND: alu_res = a_q & op2;
			SLL: alu_res = a_q << op2[4:0];
			SRL: alu_res = a_q >> op2[4:0];
			default: alu_res = $signed(a_q) >>> op2[4:0];
		endcase
	end

	// Flags are held with R for the sequencer to test
	always_ff @(posedge clk) begin
		if (reset) begin
			o_flags <= '0;
		end else if (i_ctrl.load_r) begin
			o_flags <= '{z: (alu_res == '0), n: alu_res[XLEN-1], c: alu_c, v: alu_v};
		end
	end

	always_ff @(posedge clk) begin
		if (i_ctrl.load_r) begin
			o_result <= alu_res;
			m_q      <= b_q;  // Store data follows the address
		end
		if (i_ctrl.load_y) begin
			y_q <= i_ctrl.y_sel[1] ? {{(XLEN-1){1'b0}}, i_ctrl.y_sel[0]} : o_result;
		end
	end

	assign o_store_src = m_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			o_pc <= '0;
		end else if (i_ctrl.pc_load) begin
			o_pc <= o_pc + (i_ctrl.pc_branch ? i_decoded.imm : XLEN'(4));
		end
	end

endmodule

// ==== source/fetch_decode.sv ====
/*
 * Fetch/decode
 * Holds the instruction register and splits the instruction into
 * fields and a sign-extended immediate. In DECODE the arriving word
 * is decoded directly so the sequencer can act on it in that cycle.
 */
`timescale 1ns/1ps

module fetch_decode (
	input  logic                     clk,
	input  logic                     reset,
	input  logic [cpu_pkg::XLEN-1:0] i_instr,
	input  logic                     i_capture,
	output cpu_pkg::decoded_t        o_decoded
);
	import cpu_pkg::*;

	logic [XLEN-1:0] ir;
	logic [XLEN-1:0] word;
	logic            known;

	always_ff @(posedge clk) begin
		if (reset) begin
			ir <= '0;  // Decodes as a no-op
		end else if (i_capture) begin
			ir <= i_instr;
		end
	end

	assign word = i_capture ? i_instr : ir;  // Bypass while capturing

	always_comb begin
		case (word[6:0])
			ALU_R, ALU_IMM, LOAD, STORE, LUI, BRANCH: known = 1'b1;
			default: known = 1'b0;
		endcase

		o_decoded.opcode = known ? opcode_e'(word[6:0]) : ALU_IMM;
		o_decoded.funct3 = known ? word[14:12] : 3'd0;
		o_decoded.funct7 = word[30];
		o_decoded.rs1    = word[19:15];
		o_decoded.rs2    = word[24:20];
		o_decoded.rd     = known ? word[11:7] : '0;  // Unknown turns into addi x0

		case (o_decoded.opcode)
			ALU_IMM, LOAD: o_decoded.imm = {{20{word[31]}}, word[31:20]};
			STORE: o_decoded.imm = {{20{word[31]}}, word[31:25], word[11:7]};
			BRANCH: begin
				o_decoded.imm = {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
			end
			LUI: o_decoded.imm = {word[31:12], 12'd0};
			default: o_decoded.imm = '0;  // R-type has no immediate
		endcase
	end

endmodule

// ==== source/load_store_unit.sv ====
/*
 * Load/store unit
 * Drives the data port: byte enables and store data by access size,
 * and sign or zero extension of load data. Stalls while a request waits.
 */
`timescale 1ns/1ps

module load_store_unit (
	input  cpu_pkg::ctrl_t           i_ctrl,
	input  cpu_pkg::decoded_t        i_decoded,
	input  logic [cpu_pkg::XLEN-1:0] i_addr,
	input  logic [cpu_pkg::XLEN-1:0] i_store_src,
	input  logic [cpu_pkg::XLEN-1:0] i_ldst_rddata,
	input  logic                     i_waitrequest,
	output logic                     o_ldst_rd,
	output logic                     o_ldst_wr,
	output logic [3:0]               o_ldst_byte_en,
	output logic [cpu_pkg::XLEN-1:0] o_ldst_addr,
	output logic [cpu_pkg::XLEN-1:0] o_ldst_wrdata,
	output logic [cpu_pkg::XLEN-1:0] o_load_value,
	output logic                     o_stall
);
	import cpu_pkg::*;

	assign o_ldst_rd   = i_ctrl.mem_rd;
	assign o_ldst_wr   = i_ctrl.mem_wr;
	assign o_ldst_addr = i_addr;
	assign o_stall     = (i_ctrl.mem_rd || i_ctrl.mem_wr) && i_waitrequest;

	always_comb begin
		case (i_decoded.funct3[1:0])
			2'b00: begin  // Byte
				o_ldst_byte_en = 4'b0001;
				o_ldst_wrdata  = {{(XLEN-8){1'b0}}, i_store_src[7:0]};
			end
			2'b01: begin  // Half
				o_ldst_byte_en = 4'b0011;
				o_ldst_wrdata  = {{(XLEN-16){1'b0}}, i_store_src[15:0]};
			end
			default: begin
				o_ldst_byte_en = 4'b1111;
				o_ldst_wrdata  = i_store_src;
			end
		endcase

		case (i_decoded.funct3)
			3'd0: o_load_value = {{(XLEN-8){i_ldst_rddata[7]}}, i_ldst_rddata[7:0]};
			3'd1: o_load_value = {{(XLEN-16){i_ldst_rddata[15]}}, i_ldst_rddata[15:0]};
			3'd4: o_load_value = {{(XLEN-8){1'b0}}, i_ldst_rddata[7:0]};
			3'd5: o_load_value = {{(XLEN-16){1'b0}}, i_ldst_rddata[15:0]};
			default: o_load_value = i_ldst_rddata;
		endcase
	end

endmodule

// ==== source/register_file.sv ====
/*
 * Register file
 * Two combinational read ports and one write port; x0 always reads 0.
 * The whole array is also exposed for debug.
 */
`timescale 1ns/1ps

module register_file #(
	parameter int NUM_REGS = 32
)(
	input  logic                           clk,
	input  logic                           reset,
	input  logic [cpu_pkg::REG_ADDR_W-1:0] i_addr_a,
	input  logic [cpu_pkg::REG_ADDR_W-1:0] i_addr_b,
	input  logic [cpu_pkg::REG_ADDR_W-1:0] i_addr_w,
	input  logic [cpu_pkg::XLEN-1:0]       i_data_w,
	input  logic                           i_we,
	output logic [cpu_pkg::XLEN-1:0]       o_data_a,
	output logic [cpu_pkg::XLEN-1:0]       o_data_b,
	output logic [cpu_pkg::XLEN-1:0]       o_regs [0:NUM_REGS-1]
);
	import cpu_pkg::*;

	// Indices past NUM_REGS read as zero
	assign o_data_a = (i_addr_a < NUM_REGS) ? o_regs[i_addr_a] : '0;
	assign o_data_b = (i_addr_b < NUM_REGS) ? o_regs[i_addr_b] : '0;

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				o_regs[i] <= '0;
			end
		end else if (i_we && i_addr_w != '0 && i_addr_w < NUM_REGS) begin
			o_regs[i_addr_w] <= i_data_w;
		end
	end

endmodule

// ==== source/sequencer.sv ====
/*
 * Sequencer
 * Steps each instruction through FETCH, DECODE, EXECUTE, RESULT and
 * RETIRE as its class needs, and drives the datapath controls.
 * The state holds while a load/store request is waiting.
 */
`timescale 1ns/1ps

module sequencer (
	input  logic              clk,
	input  logic              reset,
	input  cpu_pkg::decoded_t i_decoded,
	input  cpu_pkg::flags_t   i_flags,
	input  logic              i_stall,
	output cpu_pkg::ctrl_t    o_ctrl,
	output logic              o_capture,
	output logic              o_fetch
);
	import cpu_pkg::*;

	state_e  state;
	state_e  next_state;
	alu_op_e alu_op;
	logic    lt;
	logic    ltu;
	logic    take;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= RESET;
		end else if (!i_stall) begin
			state <= next_state;
		end
	end

	// Condition bits from the flags of the last subtract
	assign lt  = i_flags.n ^ i_flags.v;
	assign ltu = i_flags.c;

	always_comb begin
		case (i_decoded.funct3[2:1])
			2'b10: take = lt;
			2'b11: take = ltu;
			default: take = i_flags.z;
		endcase
		take = take ^ i_decoded.funct3[0];  // Odd funct3 inverts the test
	end

	always_comb begin
		case (i_decoded.opcode)
			LOAD, STORE: alu_op = ADD;  // Effective address
			BRANCH: alu_op = SUB;
			default: begin
				case (i_decoded.funct3)
					3'd0: alu_op = (i_decoded.opcode == ALU_R && i_decoded.funct7) ? SUB : ADD;
					3'd1: alu_op = SLL;
					3'd2, 3'd3: alu_op = SUB;  // slt and sltu compare
					3'd4: alu_op = XOR;
					3'd5: alu_op = i_decoded.funct7 ? SRA : SRL;
					3'd6: alu_op = OR;
					default: alu_op = AND;
				endcase
			end
		endcase
	end

	always_comb begin
		o_ctrl = '0;
		o_ctrl.alu_op = alu_op;
		o_ctrl.op2_imm = (i_decoded.opcode == ALU_IMM) || (i_decoded.opcode == LOAD) ||
			(i_decoded.opcode == STORE);
		next_state = state;

		case (state)
			RESET: next_state = FETCH;
			FETCH: next_state = DECODE;
			DECODE: begin
				if (i_decoded.opcode == LUI) begin
					o_ctrl.rf_we = 1'b1;
					o_ctrl.rf_from_imm = 1'b1;
					o_ctrl.pc_load = 1'b1;
					next_state = FETCH;
				end else begin
					o_ctrl.load_ab = 1'b1;
					next_state = EXECUTE;
				end
			end
			EXECUTE: begin
				o_ctrl.load_r = 1'b1;
				next_state = RESULT;
			end
			RESULT: begin
				case (i_decoded.opcode)
					STORE: begin
						o_ctrl.mem_wr = 1'b1;
						o_ctrl.pc_load = !i_stall;  // Advance only once accepted
						next_state = FETCH;
					end
					LOAD: begin
						o_ctrl.mem_rd = 1'b1;
						next_state = RETIRE;
					end
					BRANCH: begin
						o_ctrl.pc_load = 1'b1;
						o_ctrl.pc_branch = take;
						next_state = FETCH;
					end
					default: begin
						if (i_decoded.funct3 == 3'd2) begin
							o_ctrl.y_sel = {1'b1, lt};
						end else if (i_decoded.funct3 == 3'd3) begin
							o_ctrl.y_sel = {1'b1, ltu};
						end
						o_ctrl.load_y = 1'b1;
						next_state = RETIRE;
					end
				endcase
			end
			RETIRE: begin
				o_ctrl.rf_we = 1'b1;
				o_ctrl.rf_from_mem = (i_decoded.opcode == LOAD);
				o_ctrl.pc_load = 1'b1;
				next_state = FETCH;
			end
			default: next_state = FETCH;
		endcase
	end

	assign o_fetch   = (state == FETCH);
	assign o_capture = (state == DECODE);

endmodule

// ==== src.f ====
source/cpu_pkg.sv
source/register_file.sv
source/fetch_decode.sv
source/sequencer.sv
source/execute_unit.sv
source/load_store_unit.sv
source/cpu_top.sv
verification/cpu_tb_memory.sv
verification/cpu_tb.sv

// ==== verification/cpu_golden.hex ====
// Words by address: @000 program, @080 load data, @100 halt address per section,
// @110 expected (section reg value), @180 stores (addr byte_en data); ffffffff ends a list
@000
00500093 FFD00113 002081B3 40208233 002092B3 40115333 001153B3 00112433
001134B3 FFF0C513 0300E593 0F017613 00409693 40115713 00115793 FFF0B813
FFF0A893 00708013 00000063 ABCDE937 000019B7 00000063 20000A13 052A2023
04AA1223 04DA0423 04AA0623 00000063 000A0A83 000A1B03 000A2B83 000A4C03
000A5C83 040A2D03 00000063 00108463 001DED93 00208463 001E6E13 00209463
002DED93 00109463 002E6E13 00114463 004DED93 0020C463 004E6E13 0020D463
008DED93 00115463 008E6E13 0020E463 010DED93 00116463 010E6E13 00117463
020DED93 0020F463 020E6E13 00000063
@080
1234F08F
@100
00000048 00000054 0000006C 00000088 000000EC FFFFFFFF
@110
0 01 00000005 0 02 FFFFFFFD 0 03 00000002 0 04 00000008 0 05 A0000000
0 06 FFFFFFFF 0 07 07FFFFFF 0 08 00000001 0 09 00000000 0 0A FFFFFFFA
0 0B 00000035 0 0C 000000F0 0 0D 00000050 0 0E FFFFFFFE 0 0F 7FFFFFFE
0 10 00000001 0 11 00000000 1 12 ABCDE000 1 13 00001000 2 14 00000200
3 15 FFFFFF8F 3 16 FFFFF08F 3 17 1234F08F 3 18 0000008F 3 19 0000F08F
3 1A ABCDE000 4 1B 00000000 4 1C 0000003F FFFFFFFF
@180
00000240 F ABCDE000 00000244 3 0000FFFA 00000248 1 00000050
0000024C 1 000000FA FFFFFFFF

// ==== verification/cpu_tb.sv ====
/*
 * CPU testbench
 * Runs the golden program section by section, compares the register
 * file at each section's halt and every store request with golden data
 */
`timescale 1ns/1ps

module cpu_tb;
	localparam int HALT_BASE = 'h100;  // Halt address per section
	localparam int EXP_BASE  = 'h110;  // Triples of section, register, value
	localparam int ST_BASE   = 'h180;  // Triples of address, byte enable, data

	logic        clk = 1'b0;
	logic        reset = 1'b1;
	logic [31:0] pc_addr, pc_rddata, ldst_addr, ldst_rddata, ldst_wrdata;
	logic        pc_rd, ldst_rd, ldst_wr, waitrequest;
	logic [3:0]  pc_byte_en, ldst_byte_en;
	logic [31:0] tb_regs [0:31];
	logic [31:0] gold [0:511];
	logic [31:0] exp_regs [0:31];
	logic [31:0] held_addr, held_data;
	logic [3:0]  held_be;
	logic [1:0]  held_cmd;
	logic        held = 1'b0;
	logic        done = 1'b0;
	int errors = 0, passed = 0, failed = 0;
	int sec = 0, n_sec = 0, st_idx = 0, n_st = 0, sec_errs = 0, cycles = 0, limit;
	string names [0:4] = '{"alu", "lui", "store", "load", "branch"};

	always #50 clk = ~clk;

	cpu_top #(.NUM_REGS(32)) DUT (
		.clk (clk), .reset (reset),
		.o_pc_addr (pc_addr), .o_pc_rd (pc_rd), .i_pc_rddata (pc_rddata),
		.o_pc_byte_en (pc_byte_en), .o_ldst_addr (ldst_addr), .o_ldst_rd (ldst_rd),
		.o_ldst_wr (ldst_wr), .i_ldst_rddata (ldst_rddata), .o_ldst_wrdata (ldst_wrdata),
		.o_ldst_byte_en (ldst_byte_en), .i_ldst_waitrequest (waitrequest),
		.o_tb_regs (tb_regs)
	);

	cpu_tb_memory #(.SEED(32'hd635)) u_memory (
		.clk (clk), .reset (reset),
		.i_pc_addr (pc_addr), .i_pc_rd (pc_rd), .o_pc_rddata (pc_rddata),
		.i_ldst_addr (ldst_addr), .i_ldst_rd (ldst_rd), .i_ldst_wr (ldst_wr),
		.i_ldst_wrdata (ldst_wrdata), .i_ldst_byte_en (ldst_byte_en),
		.o_ldst_rddata (ldst_rddata), .o_ldst_waitrequest (waitrequest)
	);

	task automatic report_test(input string name, input int errs_before);
		if (errors == errs_before) begin
			passed++;
			$display("test %s: ok", name);
		end else begin
			failed++;
			$display("test %s: %0d errors", name, errors - errs_before);
		end
	endtask

	task automatic check_idle();
		assert (!pc_rd && !ldst_rd && !ldst_wr) else begin
			$display("FAIL {o_pc_rd,o_ldst_rd,o_ldst_wr} exp 0 got %h",
				{pc_rd, ldst_rd, ldst_wr});
			errors++;
		end
		for (int i = 0; i < 32; i++) begin
			assert (tb_regs[i] == '0) else begin
				$display("FAIL o_tb_regs[%0d] exp 00000000 got %h", i, tb_regs[i]);
				errors++;
			end
		end
	endtask

	task automatic compare_regs();
		for (int i = EXP_BASE; gold[i] != 32'hffffffff; i += 3) begin
			if (gold[i] == sec) begin
				exp_regs[gold[i+1]] = gold[i+2];
			end
		end
		for (int i = 0; i < 32; i++) begin
			assert (tb_regs[i] == exp_regs[i]) else begin
				$display("FAIL o_tb_regs[%0d] exp %h got %h", i, exp_regs[i], tb_regs[i]);
				errors++;
			end
		end
	endtask

	always @(negedge clk) begin
		if (!reset && !done) begin
			if (pc_rd) begin  // Instruction reads are whole words
				assert (pc_byte_en == 4'hf) else begin
					$display("FAIL o_pc_byte_en exp f got %h", pc_byte_en);
					errors++;
				end
			end
			if (held) begin  // Request must not move while waiting
				assert ({ldst_rd, ldst_wr} == held_cmd && ldst_addr == held_addr &&
					ldst_byte_en == held_be && ldst_wrdata == held_data) else begin
					$display("load/store request changed while the wait request was high");
					errors++;
				end
			end
			held      = (ldst_rd || ldst_wr) && waitrequest;
			held_cmd  = {ldst_rd, ldst_wr};
			held_addr = ldst_addr;
			held_be   = ldst_byte_en;
			held_data = ldst_wrdata;
			if (ldst_wr && !waitrequest) begin
				if (st_idx >= n_st) begin
					$display("store to %h beyond the expected store records", ldst_addr);
					errors++;
				end else begin
					assert (ldst_addr == gold[ST_BASE + 3*st_idx]) else begin
						$display("FAIL o_ldst_addr exp %h got %h",
							gold[ST_BASE + 3*st_idx], ldst_addr);
						errors++;
					end
					assert (ldst_byte_en == gold[ST_BASE + 3*st_idx + 1][3:0]) else begin
						$display("FAIL o_ldst_byte_en exp %h got %h",
							gold[ST_BASE + 3*st_idx + 1][3:0], ldst_byte_en);
						errors++;
					end
					assert (ldst_wrdata == gold[ST_BASE + 3*st_idx + 2]) else begin
						$display("FAIL o_ldst_wrdata exp %h got %h",
							gold[ST_BASE + 3*st_idx + 2], ldst_wrdata);
						errors++;
					end
				end
				st_idx++;
			end
			if (pc_rd && pc_addr == gold[HALT_BASE + sec]) begin
				compare_regs();
				if (sec == 2) begin
					assert (st_idx == n_st) else begin
						$display("only %0d of %0d stores were seen", st_idx, n_st);
						errors++;
					end
				end
				report_test(names[sec], sec_errs);
				sec_errs = errors;
				if (sec == n_sec - 1) begin
					done = 1'b1;
				end else begin
					u_memory.mem[pc_addr[9:2]] = 32'h00000013;  // Halt becomes a nop
					sec++;
				end
			end
		end
	end

	initial begin
		int reset_errs;
		$readmemh("verification/cpu_golden.hex", gold);
		for (int i = 0; i < 256; i++) begin
			u_memory.mem[i] = gold[i];
		end
		for (int i = 0; i < 32; i++) begin
			exp_regs[i] = '0;
		end
		while (gold[HALT_BASE + n_sec] != 32'hffffffff) n_sec++;
		while (gold[ST_BASE + 3*n_st] != 32'hffffffff) n_st++;
		limit = (gold[HALT_BASE + n_sec - 1] / 4 + 1) * 5 * 4 + 100;

		reset_errs = errors;
		repeat (3) begin
			@(negedge clk);
			check_idle();
		end
		@(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_idle();  // State is RESET for one more cycle
		@(negedge clk);
		assert (pc_rd) else begin
			$display("first instruction fetch missing after reset");
			errors++;
		end
		assert (pc_addr == '0) else begin
			$display("FAIL o_pc_addr exp 00000000 got %h", pc_addr);
			errors++;
		end
		report_test("reset", reset_errs);
		sec_errs = errors;

		while (!done && cycles < limit) begin
			@(posedge clk);
			cycles++;
		end
		if (!done) begin
			$display("timeout: final halt not reached within %0d cycles", limit);
			failed++;
		end
		$display("%0d tests passed, %0d tests failed", passed, failed);
		if (errors == 0 && done) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// ==== verification/cpu_tb_memory.sv ====
/*
 * Testbench memory
 * One word array shared by the instruction port (one cycle latency)
 * and the load/store port, which has a random wait request
 */
`timescale 1ns/1ps

module cpu_tb_memory #(
	parameter logic [31:0] SEED = 32'h0
)(
	input  logic        clk,
	input  logic        reset,
	input  logic [31:0] i_pc_addr,
	input  logic        i_pc_rd,
	output logic [31:0] o_pc_rddata,
	input  logic [31:0] i_ldst_addr,
	input  logic        i_ldst_rd,
	input  logic        i_ldst_wr,
	input  logic [31:0] i_ldst_wrdata,
	input  logic [3:0]  i_ldst_byte_en,
	output logic [31:0] o_ldst_rddata,
	output logic        o_ldst_waitrequest
);
	logic [31:0] mem [0:255];
	logic [1:0]  wait_cnt;
	logic [31:0] seed_var;
	logic        seeded;

	initial begin
		o_pc_rddata        = '0;
		o_ldst_rddata      = '0;
		o_ldst_waitrequest = 1'b0;
		wait_cnt           = '0;
		seeded             = 1'b0;
	end

	always @(posedge clk) begin
		if (!seeded) begin
			seed_var = SEED;
			void'($urandom(seed_var));
			seeded = 1'b1;
		end
		if (i_pc_rd) begin
			o_pc_rddata <= mem[i_pc_addr[9:2]];
		end
		if (reset) begin
			o_ldst_waitrequest <= 1'b0;
			wait_cnt           <= '0;
		end else if ((i_ldst_rd || i_ldst_wr) && o_ldst_waitrequest) begin
			wait_cnt <= wait_cnt + 2'd1;
			if (wait_cnt == 2'd2 || ($urandom % 10) < 5) begin  // At most 3 wait cycles
				o_ldst_waitrequest <= 1'b0;
			end
		end else begin
			wait_cnt           <= '0;
			o_ldst_waitrequest <= ($urandom % 10) < 3;  // Preset for the next request
		end
		if (i_ldst_rd && !o_ldst_waitrequest) begin
			o_ldst_rddata <= mem[i_ldst_addr[9:2]];
		end
		if (i_ldst_wr && !o_ldst_waitrequest) begin
			for (int b = 0; b < 4; b++) begin
				if (i_ldst_byte_en[b]) begin
					mem[i_ldst_addr[9:2]][8*b +: 8] <= i_ldst_wrdata[8*b +: 8];
				end
			end
		end
	end

endmodule
